//--- harness_consts.svh
// Shared constants for the external bus harness
// Latencies must be at least 1 and the memory depth must match the 8 bit word index

`ifndef HARNESS_CONSTS_SVH
`define HARNESS_CONSTS_SVH

// Bus widths
`define HARNESS_DATA_W 32
`define HARNESS_ADDR_W 32

// Slow memory geometry and timing
`define HARNESS_MEM_WORDS 256
`define HARNESS_MEM_LATENCY 4

// Power switch emulation
`define HARNESS_SWITCH_ACK_LATENCY 15
// cpu, peripheral, external
`define HARNESS_PWR_DOMAINS 3

// GPIO counter
`define HARNESS_GPIO_CNT_MAX 16

`endif

//--- harness_pkg.sv
// Types for the external bus harness
// Address field layout assumes 32 bit addresses and 256 words per bank

`default_nettype none

`include "harness_consts.svh"

package harness_pkg;

  // OBI request from the master
  typedef struct packed {
    logic                           req;
    logic                           we;
    logic [`HARNESS_DATA_W/8-1:0]   be;
    logic [`HARNESS_ADDR_W-1:0]     addr;
    logic [`HARNESS_DATA_W-1:0]     wdata;
  } obi_req_t;

  // OBI response to the master
  typedef struct packed {
    logic                       gnt;
    logic                       rvalid;
    logic [`HARNESS_DATA_W-1:0] rdata;
  } obi_resp_t;

  // Bit 10 picks the bank, bits 9:2 the word inside it
  typedef struct packed {
    logic [20:0] upper;
    logic        bank;
    logic [7:0]  word_idx;
    logic [1:0]  byte_off;
  } obi_addr_fields_t;

  typedef union packed {
    logic [`HARNESS_ADDR_W-1:0] raw;
    obi_addr_fields_t           f;
  } obi_addr_u;

  // Active low switch vectors, one per power domain group
  typedef struct packed {
    logic [`HARNESS_PWR_DOMAINS-1:0] cpu_switch_n;
    logic [`HARNESS_PWR_DOMAINS-1:0] periph_switch_n;
    logic [`HARNESS_PWR_DOMAINS-1:0] ext_switch_n;
  } pwr_ctrl_t;

endpackage

`default_nettype wire

//--- slow_memory.sv
// OBI word memory with a single access in flight and fixed response latency
// Writes land at grant time, rdata is zero for a write response
// Addresses wrap on the 8 bit word index, upper bits are ignored

`default_nettype none

`include "harness_consts.svh"

module slow_memory (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  harness_pkg::obi_req_t  req_i,
  output harness_pkg::obi_resp_t resp_o
);

  localparam int be_w  = `HARNESS_DATA_W / 8;
  localparam int cnt_w = $clog2(`HARNESS_MEM_LATENCY + 1);

  harness_pkg::obi_addr_u      addr_u;
  logic [7:0]                  idx;
  logic                        gnt;
  logic                        busy_q;
  logic [cnt_w-1:0]            lat_cnt_q;
  logic [`HARNESS_DATA_W-1:0]  rdata_q;
  logic [`HARNESS_DATA_W-1:0]  mem_q [`HARNESS_MEM_WORDS];

  assign addr_u.raw = req_i.addr;
  assign idx        = addr_u.f.word_idx;

  // Only one access in flight
  assign gnt = req_i.req & ~busy_q;

  // --------------------------------------------------------------------------
  // Latency counter
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q    <= 1'b0;
      lat_cnt_q <= '0;
    end else if (gnt) begin
      busy_q    <= 1'b1;
      lat_cnt_q <= cnt_w'(`HARNESS_MEM_LATENCY - 1);
    end else if (busy_q) begin
      if (lat_cnt_q == '0) begin
        busy_q <= 1'b0;
      end else begin
        lat_cnt_q <= lat_cnt_q - 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (gnt) begin
      if (req_i.we) begin
        for (int b = 0; b < be_w; b++) begin
          if (req_i.be[b]) begin
            mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
        rdata_q <= '0;
      end else begin
        // Read value frozen at grant
        rdata_q <= mem_q[idx];
      end
    end
  end

  assign resp_o.gnt    = gnt;
  assign resp_o.rvalid = busy_q && (lat_cnt_q == '0);
  assign resp_o.rdata  = rdata_q;

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  // Each response traces back to a grant exactly one latency earlier
  rvalid_after_gnt_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $rose(resp_o.rvalid) |-> $past(resp_o.gnt, `HARNESS_MEM_LATENCY)
  ) else $error("rvalid without a grant %0d cycles before", `HARNESS_MEM_LATENCY);

  // No new grant until the pending response has left
  no_gnt_in_flight_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    resp_o.gnt |=> !resp_o.gnt [* `HARNESS_MEM_LATENCY]
  ) else $error("grant while an access is outstanding");

endmodule

`default_nettype wire

//--- power_switch_emu.sv
// Emulates power switch acknowledge by delaying each request
// All three domain groups share one delay line, stages reset to off

`default_nettype none

`include "harness_consts.svh"

module power_switch_emu (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  harness_pkg::pwr_ctrl_t switch_i,
  output harness_pkg::pwr_ctrl_t ack_o
);

  localparam int depth = `HARNESS_SWITCH_ACK_LATENCY;

  harness_pkg::pwr_ctrl_t stage_q [depth];

  // --------------------------------------------------------------------------
  // Delay line
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      // Switches off
      for (int i = 0; i < depth; i++) begin
        stage_q[i] <= '1;
      end
    end else begin
      stage_q[0] <= switch_i;
      for (int i = 1; i < depth; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  // Oldest stage is the acknowledge
  assign ack_o = stage_q[depth-1];

endmodule

`default_nettype wire

//--- gpio_cnt.sv
// Counts consecutive cycles with the GPIO input high
// One cycle pulse after HARNESS_GPIO_CNT_MAX high cycles, a low cycle restarts

`default_nettype none

`include "harness_consts.svh"

module gpio_cnt (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic gpio_i,
  output logic pulse_o
);

  localparam int cnt_w = $clog2(`HARNESS_GPIO_CNT_MAX + 1);

  logic [cnt_w-1:0] cnt_q;
  logic             pulse_q;
  logic             at_max;

  // Last high cycle of a full run
  assign at_max = gpio_i && (cnt_q == cnt_w'(`HARNESS_GPIO_CNT_MAX - 1));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q   <= '0;
      pulse_q <= 1'b0;
    end else begin
      pulse_q <= at_max;
      if (!gpio_i || at_max) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign pulse_o = pulse_q;

  // Count restarts at the limit, so pulses are isolated
  single_cycle_pulse_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    pulse_o |=> !pulse_o
  ) else $error("gpio pulse longer than one cycle");

endmodule

`default_nettype wire

//--- ext_periph_harness.sv
// External bus slave harness with two slow memories, power ack emulation and GPIO counter
// Bank picked by address bit 10, each bank keeps one access in flight
// Master must hold a request stable until it is granted

`default_nettype none

module ext_periph_harness (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  harness_pkg::obi_req_t  obi_req_i,
  output harness_pkg::obi_resp_t obi_resp_o,
  input  harness_pkg::pwr_ctrl_t pwr_switch_i,
  output harness_pkg::pwr_ctrl_t pwr_ack_o,
  input  logic                   gpio_i,
  output logic                   gpio_pulse_o
);

  harness_pkg::obi_addr_u        addr_u;
  harness_pkg::obi_req_t  [1:0]  bank_req;
  harness_pkg::obi_resp_t [1:0]  bank_resp;

  // --------------------------------------------------------------------------
  // Bank decode
  // --------------------------------------------------------------------------
  assign addr_u.raw = obi_req_i.addr;

  always_comb begin
    for (int b = 0; b < 2; b++) begin
      bank_req[b]     = obi_req_i;
      bank_req[b].req = obi_req_i.req && (addr_u.f.bank == 1'(b));
    end
  end

  // --------------------------------------------------------------------------
  // Slow memories
  // --------------------------------------------------------------------------
  for (genvar b = 0; b < 2; b++) begin : gen_bank
    slow_memory i_slow_memory (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (bank_req[b]),
      .resp_o  (bank_resp[b])
    );
  end

  // --------------------------------------------------------------------------
  // Response merge
  // --------------------------------------------------------------------------
  always_comb begin
    obi_resp_o.gnt    = bank_resp[addr_u.f.bank].gnt;
    obi_resp_o.rvalid = bank_resp[0].rvalid | bank_resp[1].rvalid;
    if (bank_resp[0].rvalid) begin
      obi_resp_o.rdata = bank_resp[0].rdata;
    end else if (bank_resp[1].rvalid) begin
      obi_resp_o.rdata = bank_resp[1].rdata;
    end else begin
      obi_resp_o.rdata = '0;
    end
  end

  // --------------------------------------------------------------------------
  // Power switch and GPIO
  // --------------------------------------------------------------------------
  power_switch_emu i_power_switch_emu (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .switch_i (pwr_switch_i),
    .ack_o    (pwr_ack_o)
  );

  gpio_cnt i_gpio_cnt (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .gpio_i  (gpio_i),
    .pulse_o (gpio_pulse_o)
  );

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  // Grants land in distinct cycles and latency is fixed, so responses never overlap
  rvalid_exclusive_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !(bank_resp[0].rvalid && bank_resp[1].rvalid)
  ) else $error("both banks returned rvalid in one cycle");

  // Master holds the request until granted
  req_held_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    obi_req_i.req && !obi_resp_o.gnt |=> obi_req_i.req && $stable(obi_req_i.addr)
  ) else $error("request dropped or changed before grant");

endmodule

`default_nettype wire

//--- tb_ext_periph_harness.sv
// Testbench for the external bus harness, one OBI master driven on the falling edge
// Memory reads are expected only at addresses that were written earlier in the run

`default_nettype none

`include "harness_consts.svh"

module tb_ext_periph_harness;

  localparam time clk_period    = 10;
  localparam time resp_delay    = `HARNESS_MEM_LATENCY * clk_period;
  localparam int  grant_timeout = 100;
  localparam int  drain_timeout = 200;
  localparam int  pwr_w         = $bits(harness_pkg::pwr_ctrl_t);
  localparam int  num_words     = 16;
  localparam int  gpio_runs     = 3;

  typedef struct packed {
    logic [`HARNESS_DATA_W-1:0] rdata;
    logic [63:0]                gnt_time;
  } expect_t;

  logic                   clk;
  logic                   rst_n;
  harness_pkg::obi_req_t  obi_req;
  harness_pkg::obi_resp_t obi_resp;
  harness_pkg::pwr_ctrl_t pwr_switch;
  harness_pkg::pwr_ctrl_t pwr_ack;
  logic                   gpio;
  logic                   gpio_pulse;

  logic [15:0]                lfsr_q;
  logic [31:0]                word_addr [num_words];
  logic [`HARNESS_DATA_W-1:0] model_mem [2*`HARNESS_MEM_WORDS];
  expect_t                    exp_q [$];
  harness_pkg::pwr_ctrl_t     pwr_hist [$];
  int                         gpio_run = 0;
  logic                       pulse_exp = 1'b0;
  int                         pulse_seen = 0;
  int                         bus_errors = 0;
  int                         pwr_errors = 0;
  int                         gpio_errors = 0;
  int                         seq_errors = 0;

  ext_periph_harness i_dut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .obi_req_i    (obi_req),
    .obi_resp_o   (obi_resp),
    .pwr_switch_i (pwr_switch),
    .pwr_ack_o    (pwr_ack),
    .gpio_i       (gpio),
    .gpio_pulse_o (gpio_pulse)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Reference helpers
  // --------------------------------------------------------------------------
  // 16 bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val    = {val[30:0], lfsr_q[0]};
      lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
    end
    return val;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0] be);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic report_totals();
    $display("errors: bus %0d power %0d gpio %0d sequence %0d",
             bus_errors, pwr_errors, gpio_errors, seq_errors);
  endtask

  task automatic abort_run(input string what);
    $display("timeout: %s", what);
    report_totals();
    $display("sim failed");
    $finish;
  endtask

  // --------------------------------------------------------------------------
  // Comparison process
  // --------------------------------------------------------------------------
  task automatic check_bus();
    harness_pkg::obi_addr_u a;
    logic [8:0]             key;
    expect_t                e;
    // Retire responses before recording a grant on the same edge
    if (obi_resp.rvalid) begin
      if (exp_q.size() == 0) begin
        bus_errors++;
        $display("error @%0t: rvalid with nothing outstanding", $time);
      end else begin
        e = exp_q.pop_front();
        if (obi_resp.rdata !== e.rdata) begin
          bus_errors++;
          $display("error @%0t: rdata %h, expected %h", $time, obi_resp.rdata, e.rdata);
        end
        if ($time - e.gnt_time != resp_delay) begin
          bus_errors++;
          $display("error @%0t: rvalid %0t after grant", $time, $time - e.gnt_time);
        end
      end
    end else if (exp_q.size() != 0 && $time - exp_q[0].gnt_time >= resp_delay) begin
      bus_errors++;
      $display("error @%0t: rvalid missing for grant at %0t", $time, exp_q[0].gnt_time);
      void'(exp_q.pop_front());
    end
    if (obi_req.req && obi_resp.gnt) begin
      a.raw = obi_req.addr;
      key   = {a.f.bank, a.f.word_idx};
      if (obi_req.we) begin
        model_mem[key] = merge_bytes(model_mem[key], obi_req.wdata, obi_req.be);
        e.rdata        = '0;
      end else begin
        e.rdata = model_mem[key];
      end
      e.gnt_time = $time;
      exp_q.push_back(e);
    end
  endtask

  task automatic check_power();
    harness_pkg::pwr_ctrl_t exp_ack;
    exp_ack = '1;
    if (pwr_hist.size() == `HARNESS_SWITCH_ACK_LATENCY) begin
      exp_ack = pwr_hist.pop_front();
    end
    if (pwr_ack !== exp_ack) begin
      pwr_errors++;
      $display("error @%0t: pwr_ack %h, expected %h", $time, pwr_ack, exp_ack);
    end
    pwr_hist.push_back(pwr_switch);
  endtask

  task automatic check_gpio();
    if (gpio_pulse !== pulse_exp) begin
      gpio_errors++;
      $display("error @%0t: gpio_pulse %b, expected %b", $time, gpio_pulse, pulse_exp);
    end
    if (gpio_pulse === 1'b1) begin
      pulse_seen++;
    end
    if (gpio && gpio_run == `HARNESS_GPIO_CNT_MAX - 1) begin
      pulse_exp = 1'b1;
      gpio_run  = 0;
    end else begin
      pulse_exp = 1'b0;
      gpio_run  = gpio ? gpio_run + 1 : 0;
    end
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      check_bus();
      check_power();
      check_gpio();
    end else begin
      pwr_hist.delete();
      gpio_run  = 0;
      pulse_exp = 1'b0;
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  // Called at a falling edge, returns at the falling edge after the grant
  task automatic bus_access(input logic we, input logic [3:0] be, input logic [31:0] addr,
                            input logic [31:0] wdata, output time gnt_time);
    int waited;
    waited        = 0;
    gnt_time      = 0;
    obi_req.req   = 1'b1;
    obi_req.we    = we;
    obi_req.be    = be;
    obi_req.addr  = addr;
    obi_req.wdata = wdata;
    @(posedge clk);
    while (!obi_resp.gnt && waited < grant_timeout) begin
      waited++;
      @(posedge clk);
    end
    if (!obi_resp.gnt) begin
      abort_run("request was never granted");
    end else begin
      gnt_time = $time;
      @(negedge clk);
      obi_req.req = 1'b0;
    end
  endtask

  task automatic wait_responses();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < drain_timeout) begin
      waited++;
      @(negedge clk);
    end
    if (exp_q.size() != 0) begin
      abort_run("memory responses still outstanding");
    end
  endtask

  task automatic check_idle();
    repeat (4) begin
      @(posedge clk);
      if (pwr_ack !== '1 || obi_resp.gnt !== 1'b0 || obi_resp.rvalid !== 1'b0 ||
          gpio_pulse !== 1'b0) begin
        seq_errors++;
        $display("error @%0t: outputs not idle after reset", $time);
      end
    end
    @(negedge clk);
  endtask

  task automatic test_words();
    time         t;
    logic [31:0] addr;
    for (int i = 0; i < num_words; i++) begin
      word_addr[i] = {21'h0, 1'(rand_bits(1)), 8'(rand_bits(8)), 2'b00};
      bus_access(1'b1, 4'hf, word_addr[i], rand_bits(32), t);
    end
    for (int i = 0; i < num_words; i++) begin
      bus_access(1'b0, 4'hf, word_addr[i], 32'h0, t);
    end
    // Same word index in both banks
    for (int b = 0; b < 2; b++) begin
      addr = {21'h0, 1'(b), 8'h3c, 2'b00};
      bus_access(1'b1, 4'hf, addr, rand_bits(32), t);
    end
    for (int b = 0; b < 2; b++) begin
      addr = {21'h0, 1'(b), 8'h3c, 2'b00};
      bus_access(1'b0, 4'hf, addr, 32'h0, t);
    end
    wait_responses();
  endtask

  task automatic test_byte_enables();
    time t;
    bus_access(1'b1, 4'b0101, word_addr[0], rand_bits(32), t);
    bus_access(1'b0, 4'hf, word_addr[0], 32'h0, t);
    for (int i = 1; i < num_words / 2; i++) begin
      bus_access(1'b1, 4'(rand_bits(4)), word_addr[i], rand_bits(32), t);
      bus_access(1'b0, 4'hf, word_addr[i], 32'h0, t);
    end
    wait_responses();
  endtask

  task automatic test_busy_bank();
    time t_a;
    time t_b;
    time t_c;
    bus_access(1'b1, 4'hf, 32'h0000_0010, rand_bits(32), t_a);
    bus_access(1'b1, 4'hf, 32'h0000_0410, rand_bits(32), t_c);
    bus_access(1'b1, 4'hf, 32'h0000_0020, rand_bits(32), t_b);
    wait_responses();
    // Bank 0, bank 1, then bank 0 again while it is busy
    bus_access(1'b0, 4'hf, 32'h0000_0010, 32'h0, t_a);
    bus_access(1'b0, 4'hf, 32'h0000_0410, 32'h0, t_c);
    bus_access(1'b0, 4'hf, 32'h0000_0020, 32'h0, t_b);
    if (t_c - t_a != clk_period) begin
      seq_errors++;
      $display("error @%0t: idle bank granted %0t after busy bank", $time, t_c - t_a);
    end
    if (t_b - t_a <= resp_delay) begin
      seq_errors++;
      $display("error @%0t: busy bank granted before its rvalid", $time);
    end
    wait_responses();
  endtask

  task automatic test_power();
    for (int i = 0; i < 64; i++) begin
      pwr_switch = pwr_w'(rand_bits(pwr_w));
      @(negedge clk);
    end
    pwr_switch = '1;
    repeat (`HARNESS_SWITCH_ACK_LATENCY + 4) @(negedge clk);
  endtask

  task automatic test_gpio();
    int start;
    start = pulse_seen;
    gpio  = 1'b1;
    repeat (gpio_runs * `HARNESS_GPIO_CNT_MAX) @(negedge clk);
    gpio = 1'b0;
    repeat (3) @(negedge clk);
    if (pulse_seen - start != gpio_runs) begin
      seq_errors++;
      $display("error @%0t: %0d gpio pulses, expected %0d", $time, pulse_seen - start,
               gpio_runs);
    end
    // Short runs never reach the limit
    start = pulse_seen;
    for (int r = 0; r < 2; r++) begin
      gpio = 1'b1;
      repeat (`HARNESS_GPIO_CNT_MAX - 1) @(negedge clk);
      gpio = 1'b0;
      @(negedge clk);
    end
    repeat (3) @(negedge clk);
    if (pulse_seen != start) begin
      seq_errors++;
      $display("error @%0t: gpio pulse after a broken run", $time);
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    obi_req    = '0;
    pwr_switch = '1;
    gpio       = 1'b0;
    lfsr_q     = 16'd43;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    check_idle();
    test_words();
    test_byte_enables();
    test_busy_bank();
    test_power();
    test_gpio();
    repeat (5) @(negedge clk);
    report_totals();
    if (bus_errors + pwr_errors + gpio_errors + seq_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- ext_periph_harness.f
+incdir+.
harness_pkg.sv
slow_memory.sv
power_switch_emu.sv
gpio_cnt.sv
ext_periph_harness.sv
tb_ext_periph_harness.sv

//--- Makefile
# Verilator build and run for the external bus harness

VERILATOR ?= verilator
TOP       ?= tb_ext_periph_harness
FILELIST  ?= ext_periph_harness.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# Pass only when the testbench prints the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
